/* verilog/cla_pkg.sv */
package cla_pkg;

    // default operand width of the adder
    localparam int CLA_WIDTH = 32;

    // carry status of one bit position or of a group of positions
    // bit 1: carry leaves the group if a carry enters it
    // bit 0: carry leaves the group if no carry enters it
    typedef logic [1:0] pgk_t;

    // group always swallows the incoming carry
    localparam pgk_t PGK_KILL = 2'b00;

    // group passes the incoming carry through
    localparam pgk_t PGK_PROPAGATE = 2'b10;

    // group makes a carry on its own
    localparam pgk_t PGK_GENERATE = 2'b11;

    // 2'b01 cannot occur, since a generate always implies a propagate-or-generate

endpackage

/* verilog/pgk_encode.sv */
module pgk_encode import cla_pkg::*; #(
    parameter int WIDTH = CLA_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output pgk_t [WIDTH-1:0] pgk
);

    pgk_t [WIDTH-1:0] pgk_next;
    logic             carry_0;

    // bit 0 already knows its carry-in, so its pair is fully resolved
    assign carry_0 = (a[0] & b[0]) | (a[0] & cin) | (b[0] & cin);

    assign pgk_next[0] = carry_0 ? PGK_GENERATE : PGK_KILL;

    for (genvar i = 1; i < WIDTH; i++)
    begin : g_bit
        // upper bit is or, lower bit is and
        assign pgk_next[i] = {a[i] | b[i], a[i] & b[i]};
    end

    // first pipeline register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pgk <= '0;
        end
        else
        begin
            pgk <= pgk_next;
        end
    end

endmodule

/* verilog/prefix_level.sv */
module prefix_level import cla_pkg::*; #(
    parameter int WIDTH = CLA_WIDTH,
    parameter int SPAN  = 1
) (
    input  pgk_t [WIDTH-1:0] pgk_in,
    output pgk_t [WIDTH-1:0] pgk_out
);

    // each position looks SPAN places down and merges the two groups
    for (genvar i = 0; i < WIDTH; i++)
    begin : g_pos
        if (i < SPAN)
        begin : g_pass
            // nothing below within reach, group already complete
            assign pgk_out[i] = pgk_in[i];
        end
        else
        begin : g_merge
            pgk_t upper;
            pgk_t lower;

            assign upper = pgk_in[i];
            assign lower = pgk_in[i-SPAN];

            // kill and generate decide by themselves
            // a propagate hands the decision to the lower group
            always_comb
            begin
                if (upper == PGK_PROPAGATE)
                begin
                    pgk_out[i] = lower;
                end
                else
                begin
                    pgk_out[i] = upper;
                end
            end
        end
    end

endmodule

/* verilog/prefix_network.sv */
module prefix_network import cla_pkg::*; #(
    parameter int WIDTH = CLA_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  pgk_t [WIDTH-1:0] pgk,
    output logic [WIDTH-1:0] carry
);

    // spans 1, 2, 4 ... WIDTH/2
    localparam int LEVELS = $clog2(WIDTH);

    logic [WIDTH-1:0] carry_next;

    for (genvar l = 0; l < LEVELS; l++)
    begin : g_level
        pgk_t [WIDTH-1:0] level_in;
        pgk_t [WIDTH-1:0] level_out;
        pgk_t [WIDTH-1:0] stage_out;

        if (l == 0)
        begin : g_first
            assign level_in = pgk;
        end
        else
        begin : g_chain
            assign level_in = g_level[l-1].stage_out;
        end

        prefix_level #(
            .WIDTH (WIDTH),
            .SPAN  (1 << l)
        ) prefix_level_i (
            .pgk_in  (level_in),
            .pgk_out (level_out)
        );

        // register after every second level
        // the last level is registered as carries below instead
        if ((l % 2 == 1) && (l != LEVELS - 1))
        begin : g_reg
            always_ff @(posedge clk)
            begin
                if (reset)
                begin
                    stage_out <= '0;
                end
                else
                begin
                    stage_out <= level_out;
                end
            end
        end
        else
        begin : g_comb
            assign stage_out = level_out;
        end
    end

    // every final pair is resolved to kill or generate
    for (genvar i = 0; i < WIDTH; i++)
    begin : g_carry
        assign carry_next[i] = g_level[LEVELS-1].stage_out[i][1];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            carry <= '0;
        end
        else
        begin
            carry <= carry_next;
        end
    end

endmodule

/* verilog/operand_delay.sv */
module operand_delay import cla_pkg::*; #(
    parameter int WIDTH = CLA_WIDTH,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] a_d,
    output logic [WIDTH-1:0] b_d,
    output logic             cin_d
);

    // cin, b and a side by side in one word
    typedef logic [2*WIDTH:0] operand_set_t;

    operand_set_t pipe [DEPTH];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                pipe[i] <= '0;
            end
        end
        else
        begin
            pipe[0] <= {cin, b, a};
            for (int i = 1; i < DEPTH; i++)
            begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign {cin_d, b_d, a_d} = pipe[DEPTH-1];

endmodule

/* verilog/pipelined_cla.sv */
module pipelined_cla import cla_pkg::*; #(
    parameter int WIDTH = CLA_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    typedef logic [WIDTH-1:0] word_t;

    localparam int LEVELS = $clog2(WIDTH);

    // encode register plus one register per two prefix levels
    localparam int DEPTH = 1 + (LEVELS + 1) / 2;

    pgk_t [WIDTH-1:0] pgk;
    word_t            carry;
    word_t            a_d;
    word_t            b_d;
    logic             cin_d;

    pgk_encode #(
        .WIDTH (WIDTH)
    ) pgk_encode_i (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .pgk   (pgk)
    );

    prefix_network #(
        .WIDTH (WIDTH)
    ) prefix_network_i (
        .clk   (clk),
        .reset (reset),
        .pgk   (pgk),
        .carry (carry)
    );

    // operands travel alongside the carries
    operand_delay #(
        .WIDTH (WIDTH),
        .DEPTH (DEPTH)
    ) operand_delay_i (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .a_d   (a_d),
        .b_d   (b_d),
        .cin_d (cin_d)
    );

    // bit 0 sees the original carry-in
    assign sum[0] = a_d[0] ^ b_d[0] ^ cin_d;

    // higher bits take the carry out of the position below
    assign sum[WIDTH-1:1] = a_d[WIDTH-1:1] ^ b_d[WIDTH-1:1] ^ carry[WIDTH-2:0];

    assign cout = carry[WIDTH-1];

endmodule

/* tb/cla_ref.svh */
`ifndef CLA_REF_SVH
`define CLA_REF_SVH

// cycles from driving an operand set to checking its result
localparam int LATENCY = 4;

// expected result of one addition
// carry out sits on top of the sum
function automatic logic [CLA_WIDTH:0] ref_add(
    input logic [CLA_WIDTH-1:0] a,
    input logic [CLA_WIDTH-1:0] b,
    input logic                 cin
);
    logic [CLA_WIDTH:0] total;

    total = {1'b0, a} + {1'b0, b} + {{CLA_WIDTH{1'b0}}, cin};
    return total;
endfunction

`endif

/* tb/pipelined_cla_tb.sv */
module pipelined_cla_tb import cla_pkg::*; ();

    `include "cla_ref.svh"

    typedef logic [CLA_WIDTH-1:0] word_t;
    typedef logic [CLA_WIDTH:0]   result_t;

    // one addition waiting for its result
    typedef struct packed {
        int      due;
        word_t   a;
        word_t   b;
        logic    cin;
        result_t expected;
    } entry_t;

    localparam int NUM_RANDOM    = 200;
    localparam int NUM_DIRECTED  = 10;
    localparam int NUM_PROPAGATE = 8;
    localparam int MID_BEFORE    = 6;
    localparam int MID_AFTER     = 8;

    // every driven cycle, reset cycles included
    localparam int NUM_VECTORS = 2 + NUM_RANDOM + NUM_DIRECTED + NUM_PROPAGATE
                               + MID_BEFORE + 1 + MID_AFTER;

    logic  clk;
    logic  reset;
    word_t a;
    word_t b;
    logic  cin;
    word_t sum;
    logic  cout;

    integer seed = 32'hfa2d;
    int     cycle = 0;
    int     errors = 0;
    int     checked = 0;
    int     flushed = 0;

    entry_t pending [$];

    pipelined_cla #(
        .WIDTH (CLA_WIDTH)
    ) pipelined_cla_i (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .sum   (sum),
        .cout  (cout)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // one stimulus cycle, queued for checking unless reset is driven
    task automatic drive_cycle(
        input logic  rst,
        input word_t a_v,
        input word_t b_v,
        input logic  cin_v
    );
        entry_t entry;

        @(posedge clk);
        #1;
        reset = rst;
        a     = a_v;
        b     = b_v;
        cin   = cin_v;
        if (!rst)
        begin
            entry.due      = cycle + LATENCY;
            entry.a        = a_v;
            entry.b        = b_v;
            entry.cin      = cin_v;
            entry.expected = ref_add(a_v, b_v, cin_v);
            pending.push_back(entry);
        end
    endtask

    task automatic random_ops(input int count);
        logic [31:0] rnd;
        word_t       a_v;
        word_t       b_v;

        for (int i = 0; i < count; i++)
        begin
            a_v = $random(seed);
            b_v = $random(seed);
            rnd = $random(seed);
            drive_cycle(1'b0, a_v, b_v, rnd[0]);
        end
    endtask

    // carries that ripple across the whole word
    task automatic carry_chain_ops();
        word_t ones;
        word_t alt_a;
        word_t alt_5;

        ones  = '1;
        alt_a = {(CLA_WIDTH / 2){2'b10}};
        alt_5 = {(CLA_WIDTH / 2){2'b01}};
        drive_cycle(1'b0, ones, word_t'(1), 1'b0);
        drive_cycle(1'b0, ones, '0, 1'b1);
        drive_cycle(1'b0, '0, '0, 1'b0);
        drive_cycle(1'b0, '0, '0, 1'b1);
        drive_cycle(1'b0, alt_a, alt_5, 1'b0);
        drive_cycle(1'b0, alt_a, alt_5, 1'b1);
        drive_cycle(1'b0, alt_5, alt_a, 1'b1);
        drive_cycle(1'b0, alt_a, alt_a, 1'b0);
        drive_cycle(1'b0, alt_5, alt_5, 1'b1);
        drive_cycle(1'b0, ones, ones, 1'b1);
    endtask

    // b is the inverse of a, so every position propagates
    task automatic propagate_ops(input int count);
        word_t a_v;

        for (int i = 0; i < count; i++)
        begin
            a_v = $random(seed);
            drive_cycle(1'b0, a_v, ~a_v, i[0]);
        end
    endtask

    task automatic check_result(input entry_t entry);
        checked++;
        if ({cout, sum} !== entry.expected)
        begin
            errors++;
            $display(
                "** Error at %0t: a=%h b=%h cin=%b expected cout=%b sum=%h, got cout=%b sum=%h",
                $time, entry.a, entry.b, entry.cin, entry.expected[CLA_WIDTH],
                entry.expected[CLA_WIDTH-1:0], cout, sum);
        end
    endtask

    task automatic check_zero();
        checked++;
        if (sum !== '0 || cout !== 1'b0)
        begin
            errors++;
            $display("** Error at %0t: outputs not cleared by reset, got cout=%b sum=%h",
                     $time, cout, sum);
        end
    endtask

    // outputs are sampled mid-cycle, well clear of both edges
    initial
    begin : compare
        entry_t entry;
        logic   reset_seen;
        int     zero_until;

        zero_until = 0;
        forever
        begin
            @(posedge clk);
            reset_seen = reset;
            @(negedge clk);
            if (reset_seen)
            begin
                zero_until = cycle + LATENCY - 1;
                check_zero();
                // results still in the pipeline are lost
                while (pending.size() > 0 && pending[0].due <= zero_until)
                begin
                    entry = pending.pop_front();
                    flushed++;
                end
            end
            else
            begin
                if (pending.size() > 0 && pending[0].due == cycle)
                begin
                    entry = pending.pop_front();
                    check_result(entry);
                end
                else if (cycle <= zero_until)
                begin
                    check_zero();
                end
            end
        end
    end

    initial
    begin : stimulus
        reset = 1'b1;
        a     = '0;
        b     = '0;
        cin   = 1'b0;

        drive_cycle(1'b1, '0, '0, 1'b0);
        random_ops(NUM_RANDOM);
        carry_chain_ops();
        propagate_ops(NUM_PROPAGATE);

        // single reset cycle with additions in flight
        random_ops(MID_BEFORE);
        drive_cycle(1'b1, '0, '0, 1'b0);
        random_ops(MID_AFTER);

        repeat (LATENCY + 2) @(posedge clk);

        if (pending.size() != 0)
        begin
            errors++;
            $display("%0d expected results never appeared at the outputs", pending.size());
        end

        $display("checked %0d, flushed %0d, errors %0d", checked, flushed, errors);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial
    begin : watchdog
        #((NUM_VECTORS + 20) * 10);
        $display("watchdog expired in cycle %0d before the stimulus finished", cycle);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+tb
verilog/cla_pkg.sv
verilog/pgk_encode.sv
verilog/prefix_level.sv
verilog/prefix_network.sv
verilog/operand_delay.sv
verilog/pipelined_cla.sv
tb/pipelined_cla_tb.sv

/* Makefile */
# Verilator build and run of the pipelined adder testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module pipelined_cla_tb \
		-Mdir obj_dir -o pipelined_cla_sim
	./obj_dir/pipelined_cla_sim | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
